// File: div_pkg.sv
// shared constants and result layout for the divide farm
// operands are WORD_W bits, a result packs rem above quot
`default_nettype none

package div_pkg;

  // --------------------
  // word sizes
  // --------------------

  // operand width, every datapath bus is sized from this
  localparam int WORD_W = 32;

  // a result carries two words
  localparam int RESULT_W = 2 * WORD_W;

  // width of the step counter in a lane, one step per quotient bit
  localparam int STEP_W = $clog2(WORD_W);

  // --------------------
  // function codes
  // --------------------

  localparam logic FN_UNSIGNED = 1'b0;
  localparam logic FN_SIGNED = 1'b1;

  // --------------------
  // result word
  // --------------------

  // raw is the opaque word moved by the collector and the output port
  // fields is the view the lane writes and the testbench checks
  typedef union packed {
    logic [RESULT_W-1:0] raw;
    struct packed {
      logic [WORD_W-1:0] rem;
      logic [WORD_W-1:0] quot;
    } fields;
  } div_result_u;

endpackage

`default_nettype wire

// File: div_lane.sv
// iterative restoring divider, one result per WORD_W calculate cycles
// one request at a time, req_rdy only while idle
`timescale 1ns/1ns
`default_nettype none

module div_lane (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  logic                       req_fn,
  input  logic [div_pkg::WORD_W-1:0] req_a,
  input  logic [div_pkg::WORD_W-1:0] req_b,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output div_pkg::div_result_u       resp_result
);

  import div_pkg::*;

  // fsm encodings
  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] CALC = 2'd1;
  localparam logic [1:0] DONE = 2'd2;

  // last step index, count runs 0 .. WORD_W-1
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(WORD_W - 1);

  logic [1:0]        state;
  logic [STEP_W-1:0] count;

  // remainder in [2W:W], dividend bits shifting out of / quotient into [W-1:0]
  logic [2*WORD_W:0] rq;
  logic [WORD_W-1:0] dvsr;
  logic              a_neg;
  logic              b_neg;

  // operand conditioning at acceptance
  logic              a_neg_d;
  logic              b_neg_d;
  logic [WORD_W-1:0] a_mag_d;
  logic [WORD_W-1:0] b_mag_d;

  // one restoring step
  logic [2*WORD_W:0]   shifted;
  logic [2*WORD_W+1:0] trial;
  logic [2*WORD_W:0]   rq_next;

  // result fixup
  logic [WORD_W-1:0] quot_mag;
  logic [WORD_W-1:0] rem_mag;
  logic              dvsr_zero;

  logic accept;

  assign req_rdy = (state == IDLE);
  assign resp_val = (state == DONE);
  assign accept = req_val && req_rdy;

  // --------------------
  // control
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // a step is taken on every calc edge, the last one included
          count <= count + 1'b1;
          if (count == LAST_STEP) begin
            state <= DONE;
          end
        end
        DONE: begin
          // hold the result until the collector takes it
          if (resp_val && resp_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------
  // operand signs
  // --------------------

  always_comb begin
    a_neg_d = 1'b0;
    b_neg_d = 1'b0;
    case (req_fn)
      FN_UNSIGNED: begin
        a_neg_d = 1'b0;
        b_neg_d = 1'b0;
      end
      FN_SIGNED: begin
        a_neg_d = req_a[WORD_W-1];
        b_neg_d = req_b[WORD_W-1];
      end
      default: ;
    endcase
    // most negative input maps to 2**(W-1), still correct as unsigned
    a_mag_d = a_neg_d ? (~req_a + 1'b1) : req_a;
    b_mag_d = b_neg_d ? (~req_b + 1'b1) : req_b;
  end

  // --------------------
  // datapath
  // --------------------

  // trial difference is one bit wider than rq, remainder can reach 2**W after shift
  assign shifted = {rq[2*WORD_W-1:0], 1'b0};
  assign trial = {1'b0, shifted} - {2'b00, dvsr, {WORD_W{1'b0}}};

  // borrow means restore, quotient bit 0
  assign rq_next = trial[2*WORD_W+1] ? shifted : {trial[2*WORD_W:1], 1'b1};

  always_ff @(posedge clk) begin
    if (accept) begin
      rq <= {{(WORD_W+1){1'b0}}, a_mag_d};
      dvsr <= b_mag_d;
      a_neg <= a_neg_d;
      b_neg <= b_neg_d;
    end else if (state == CALC) begin
      rq <= rq_next;
    end
  end

  // --------------------
  // result
  // --------------------

  assign quot_mag = rq[WORD_W-1:0];
  assign rem_mag = rq[2*WORD_W-1:WORD_W];
  assign dvsr_zero = (dvsr == '0);

  always_comb begin
    // quotient toward zero, negative when operand signs differ
    if (dvsr_zero) begin
      resp_result.fields.quot = '1;
    end else if (a_neg ^ b_neg) begin
      resp_result.fields.quot = ~quot_mag + 1'b1;
    end else begin
      resp_result.fields.quot = quot_mag;
    end
    // remainder follows the dividend sign
    // a zero divisor leaves the dividend magnitude here, so this gives the dividend back
    resp_result.fields.rem = a_neg ? (~rem_mag + 1'b1) : rem_mag;
  end

endmodule

`default_nettype wire

// File: div_dispatch.sv
// four-phase input port feeding the lanes in round-robin order
// stalls in_ack while the pointed lane is busy
`timescale 1ns/1ns
`default_nettype none

module div_dispatch #(
  parameter int NUM_LANES = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_req,
  input  logic                       in_fn,
  input  logic [div_pkg::WORD_W-1:0] in_a,
  input  logic [div_pkg::WORD_W-1:0] in_b,
  output logic                       in_ack,
  output logic [NUM_LANES-1:0]       lane_req_val,
  input  logic [NUM_LANES-1:0]       lane_req_rdy,
  output logic                       lane_fn,
  output logic [div_pkg::WORD_W-1:0] lane_a,
  output logic [div_pkg::WORD_W-1:0] lane_b
);

  localparam int PTR_W = $clog2(NUM_LANES);
  localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

  // fsm encodings
  localparam logic [1:0] WAIT_REQ  = 2'd0;
  localparam logic [1:0] ISSUE     = 2'd1;
  localparam logic [1:0] WAIT_DROP = 2'd2;

  logic [1:0]       state;
  logic [PTR_W-1:0] ptr;
  logic             take;

  // only the pointed lane counts, order must match the collector
  assign take = (state == WAIT_REQ) && in_req && lane_req_rdy[ptr];

  // ack stays up from the issue until in_req has dropped
  assign in_ack = (state != WAIT_REQ);

  // one val cycle to the pointed lane
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_req_val[i] = (state == ISSUE) && (ptr == PTR_W'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= WAIT_REQ;
      ptr <= '0;
    end else begin
      case (state)
        WAIT_REQ: begin
          if (take) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          // lane takes the operands on this edge
          ptr <= (ptr == LAST_LANE) ? '0 : ptr + 1'b1;
          state <= in_req ? WAIT_DROP : WAIT_REQ;
        end
        WAIT_DROP: begin
          if (!in_req) begin
            state <= WAIT_REQ;
          end
        end
        default: state <= WAIT_REQ;
      endcase
    end
  end

  // holding registers, shared operand bus for every lane
  always_ff @(posedge clk) begin
    if (take) begin
      lane_fn <= in_fn;
      lane_a <= in_a;
      lane_b <= in_b;
    end
  end

endmodule

`default_nettype wire

// File: div_collect.sv
// drains lanes in round-robin order onto the four-phase output port
// results leave in the same order the dispatcher issued them
`timescale 1ns/1ns
`default_nettype none

module div_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [NUM_LANES-1:0] lane_resp_val,
  output logic [NUM_LANES-1:0] lane_resp_rdy,
  input  div_pkg::div_result_u lane_resp_result [NUM_LANES],
  output logic                 out_req,
  output div_pkg::div_result_u out_result,
  input  logic                 out_ack
);

  import div_pkg::*;

  localparam int PTR_W = $clog2(NUM_LANES);
  localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

  // fsm encodings
  localparam logic [1:0] WAIT_VAL = 2'd0;
  localparam logic [1:0] PULSE    = 2'd1;
  localparam logic [1:0] SEND     = 2'd2;
  localparam logic [1:0] DROP     = 2'd3;

  logic [1:0]          state;
  logic [PTR_W-1:0]    ptr;
  logic [RESULT_W-1:0] result_raw;

  assign out_req = (state == SEND);
  assign out_result.raw = result_raw;

  // rdy pulse frees the pointed lane one cycle after its result was latched
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_resp_rdy[i] = (state == PULSE) && (ptr == PTR_W'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= WAIT_VAL;
      ptr <= '0;
    end else begin
      case (state)
        WAIT_VAL: begin
          if (lane_resp_val[ptr]) begin
            state <= PULSE;
          end
        end
        PULSE: state <= SEND;
        SEND: begin
          if (out_ack) begin
            state <= DROP;
          end
        end
        DROP: begin
          // next lane only once the handshake is back to zero
          if (!out_ack) begin
            ptr <= (ptr == LAST_LANE) ? '0 : ptr + 1'b1;
            state <= WAIT_VAL;
          end
        end
        default: state <= WAIT_VAL;
      endcase
    end
  end

  // output register, held through the whole handshake
  always_ff @(posedge clk) begin
    if ((state == WAIT_VAL) && lane_resp_val[ptr]) begin
      result_raw <= lane_resp_result[ptr].raw;
    end
  end

endmodule

`default_nettype wire

// File: div_farm.sv
// divide farm top, NUM_LANES iterative lanes between two four-phase ports
// NUM_LANES must be at least 2
`timescale 1ns/1ns
`default_nettype none

module div_farm #(
  parameter int NUM_LANES = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_req,
  input  logic                       in_fn,
  input  logic [div_pkg::WORD_W-1:0] in_a,
  input  logic [div_pkg::WORD_W-1:0] in_b,
  output logic                       in_ack,
  output logic                       out_req,
  output div_pkg::div_result_u       out_result,
  input  logic                       out_ack
);

  import div_pkg::*;

  // request side, operand bus shared by all lanes
  logic [NUM_LANES-1:0] lane_req_val;
  logic [NUM_LANES-1:0] lane_req_rdy;
  logic                 lane_fn;
  logic [WORD_W-1:0]    lane_a;
  logic [WORD_W-1:0]    lane_b;

  // response side, one result bus per lane
  logic [NUM_LANES-1:0] lane_resp_val;
  logic [NUM_LANES-1:0] lane_resp_rdy;
  div_result_u          lane_resp_result [NUM_LANES];

  div_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .in_req       (in_req),
    .in_fn        (in_fn),
    .in_a         (in_a),
    .in_b         (in_b),
    .in_ack       (in_ack),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy),
    .lane_fn      (lane_fn),
    .lane_a       (lane_a),
    .lane_b       (lane_b)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    div_lane u_lane (
      .clk         (clk),
      .reset       (reset),
      .req_val     (lane_req_val[i]),
      .req_rdy     (lane_req_rdy[i]),
      .req_fn      (lane_fn),
      .req_a       (lane_a),
      .req_b       (lane_b),
      .resp_val    (lane_resp_val[i]),
      .resp_rdy    (lane_resp_rdy[i]),
      .resp_result (lane_resp_result[i])
    );
  end

  div_collect #(
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .clk              (clk),
    .reset            (reset),
    .lane_resp_val    (lane_resp_val),
    .lane_resp_rdy    (lane_resp_rdy),
    .lane_resp_result (lane_resp_result),
    .out_req          (out_req),
    .out_result       (out_result),
    .out_ack          (out_ack)
  );

endmodule

`default_nettype wire

// File: div_farm_checker.sv
// port handshake rules for the divide farm, bound into every div_farm
// rules are ignored while reset is high
`timescale 1ns/1ns
`default_nettype none

module div_farm_checker (
  input logic                 clk,
  input logic                 reset,
  input logic                 in_req,
  input logic                 in_ack,
  input logic                 out_req,
  input logic                 out_ack,
  input div_pkg::div_result_u out_result
);

  // number of rule violations seen so far
  int assert_fail_count = 0;

  // --------------------
  // input port
  // --------------------

  // ack only rises as the answer to a request
  in_ack_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(in_ack) |-> $past(in_req))
    else begin
      assert_fail_count++;
      $error("in_ack rose while in_req was low");
    end

  // ack drops only once the request is gone
  in_ack_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(in_ack) |-> !$past(in_req))
    else begin
      assert_fail_count++;
      $error("in_ack fell while in_req was still high");
    end

  // --------------------
  // output port
  // --------------------

  // result word must not move during the handshake
  out_stable: assert property (@(posedge clk) disable iff (reset)
    out_req && $past(out_req) |-> $stable(out_result.raw))
    else begin
      assert_fail_count++;
      $error("out_result changed while out_req was high");
    end

  // req held until the consumer acknowledged
  out_req_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(out_req) |-> $past(out_ack))
    else begin
      assert_fail_count++;
      $error("out_req fell before out_ack rose");
    end

endmodule

bind div_farm div_farm_checker u_checker (
  .clk        (clk),
  .reset      (reset),
  .in_req     (in_req),
  .in_ack     (in_ack),
  .out_req    (out_req),
  .out_ack    (out_ack),
  .out_result (out_result)
);

`default_nettype wire

// File: tb_div_farm.sv
// testbench for div_farm, vectors and expected results come from div_stim.txt
// expects the file in the working directory, out_ack delays are random with a fixed seed
`timescale 1ns/1ns
`default_nettype none

module tb_div_farm;

  import div_pkg::*;

  localparam int NUM_LANES = 4;
  localparam int DRIVE_DLY = 2;

  logic              clk;
  logic              reset;
  logic              in_req;
  logic              in_fn;
  logic [WORD_W-1:0] in_a;
  logic [WORD_W-1:0] in_b;
  logic              in_ack;
  logic              out_req;
  div_result_u       out_result;
  logic              out_ack;

  // vectors in file order, results must come back in the same order
  logic              vec_fn [$];
  logic [WORD_W-1:0] vec_a [$];
  logic [WORD_W-1:0] vec_b [$];
  div_result_u       vec_exp [$];

  int num_vec;
  int num_sent;
  int num_drained;
  int pass_count;
  int fail_count;
  int cycles;
  int cycle_limit;
  bit count_ok;

  div_farm #(
    .NUM_LANES (NUM_LANES)
  ) u_dut (
    .clk        (clk),
    .reset      (reset),
    .in_req     (in_req),
    .in_fn      (in_fn),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_result (out_result),
    .out_ack    (out_ack)
  );

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_result(input div_result_u got, input div_result_u exp, output bit ok);
    ok = 1'b1;
    if (got.fields.quot !== exp.fields.quot) begin
      $display("Fail at %0t ns: out_result.fields.quot got %h expected %h",
               $time, got.fields.quot, exp.fields.quot);
      ok = 1'b0;
    end
    if (got.fields.rem !== exp.fields.rem) begin
      $display("Fail at %0t ns: out_result.fields.rem got %h expected %h",
               $time, got.fields.rem, exp.fields.rem);
      ok = 1'b0;
    end
  endtask

  task automatic check_count(input int got, input int exp, output bit ok);
    ok = (got == exp);
    if (!ok) begin
      $display("Fail at %0t ns: result count got %0d expected %0d", $time, got, exp);
    end
  endtask

  // --------------------
  // stimulus
  // --------------------

  // comment lines start with //, data lines hold fn a b quot rem in hex
  task automatic load_vectors();
    int fd;
    int n;
    string line;
    logic fn;
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    logic [WORD_W-1:0] q;
    logic [WORD_W-1:0] r;
    div_result_u exp;
    fd = $fopen("div_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open div_stim.txt, no vectors were run");
      fail_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if ((n > 0) && (line.len() > 2) && (line.substr(0, 1) != "//")) begin
        n = $sscanf(line, "%h %h %h %h %h", fn, a, b, q, r);
        if (n == 5) begin
          exp.fields.quot = q;
          exp.fields.rem = r;
          vec_fn.push_back(fn);
          vec_a.push_back(a);
          vec_b.push_back(b);
          vec_exp.push_back(exp);
        end
      end
    end
    $fclose(fd);
    num_vec = vec_exp.size();
  endtask

  // full four-phase cycle on the input port
  task automatic send_request(input logic fn, input logic [WORD_W-1:0] a,
                              input logic [WORD_W-1:0] b);
    @(posedge clk);
    #DRIVE_DLY;
    in_fn = fn;
    in_a = a;
    in_b = b;
    in_req = 1'b1;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (!in_ack);
    in_req = 1'b0;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (in_ack);
    num_sent++;
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin : main_flow
    reset = 1'b1;
    in_req = 1'b0;
    in_fn = FN_UNSIGNED;
    in_a = '0;
    in_b = '0;
    out_ack = 1'b0;
    load_vectors();
    cycle_limit = num_vec * 50 + 200;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;
    // back to back requests, the farm keeps several lanes busy
    for (int i = 0; i < num_vec; i++) begin
      send_request(vec_fn[i], vec_a[i], vec_b[i]);
    end
    wait (num_drained >= num_vec);
    // leave room for a stray extra result to show up
    repeat (60) @(posedge clk);
    check_count(num_drained, num_vec, count_ok);
    $display("passed %0d, failed %0d, assertion failures %0d",
             pass_count, fail_count, u_dut.u_checker.assert_fail_count);
    if ((fail_count == 0) && count_ok && (u_dut.u_checker.assert_fail_count == 0)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // --------------------
  // response drain
  // --------------------

  initial begin : drain_responses
    int delay;
    bit ok;
    div_result_u got;
    delay = $urandom(90);
    wait (!reset);
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      if (out_req) begin
        got = out_result;
        if (num_drained >= num_vec) begin
          $display("extra result %h at %0t ns after the last vector", got.raw, $time);
          fail_count++;
        end else begin
          check_result(got, vec_exp[num_drained], ok);
          $display("test %0d %s %h / %h : %s", num_drained,
                   vec_fn[num_drained] ? "signed" : "unsigned",
                   vec_a[num_drained], vec_b[num_drained], ok ? "ok" : "FAILED");
          if (ok) begin
            pass_count++;
          end else begin
            fail_count++;
          end
        end
        num_drained++;
        // slow consumer, lanes back up behind the collector
        delay = $urandom_range(6, 0);
        repeat (delay) begin
          @(posedge clk);
          #DRIVE_DLY;
        end
        out_ack = 1'b1;
        do begin
          @(posedge clk);
          #DRIVE_DLY;
        end while (out_req);
        out_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stalled after %0d cycles, %0d of %0d requests acknowledged, %0d results drained",
             cycles, num_sent, num_vec, num_drained);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: div_stim.txt
// fn dividend divisor quotient remainder, all hex
// fn 0 is unsigned, fn 1 is signed
0 00000064 00000007 0000000e 00000002
0 00000005 00000009 00000000 00000005
0 12345678 00000001 12345678 00000000
0 ffffffff ffffffff 00000001 00000000
0 ffffffff 00000010 0fffffff 0000000f
0 80000000 00000003 2aaaaaaa 00000002
0 deadbeef 00001000 000deadb 00000eef
0 0000ffff 00000100 000000ff 000000ff
0 ffffffff 00000002 7fffffff 00000001
0 00000000 00000005 00000000 00000000
1 00000064 00000007 0000000e 00000002
1 ffffff9c 00000007 fffffff2 fffffffe
1 00000064 fffffff9 fffffff2 00000002
1 ffffff9c fffffff9 0000000e fffffffe
1 80000000 ffffffff 80000000 00000000
1 80000000 00000002 c0000000 00000000
1 fffffff9 00000002 fffffffd ffffffff
1 00000003 fffffff6 00000000 00000003
1 7fffffff ffffffff 80000001 00000000
1 ffffffff 00000001 ffffffff 00000000
1 80000000 80000000 00000001 00000000
0 12345678 00000000 ffffffff 12345678
0 ffffffff 00000000 ffffffff ffffffff
1 fffffff9 00000000 ffffffff fffffff9
1 00000000 00000000 ffffffff 00000000
1 7fffffff 00000000 ffffffff 7fffffff

// File: tb.f
div_pkg.sv
div_lane.sv
div_dispatch.sv
div_collect.sv
div_farm.sv
div_farm_checker.sv
tb_div_farm.sv

// File: Bender.yml
package:
  name: div_farm

sources:
  # package and RTL, in compile order
  - files:
      - div_pkg.sv
      - div_lane.sv
      - div_dispatch.sv
      - div_collect.sv
      - div_farm.sv

  # testbench and bound checker
  - target: simulation
    files:
      - div_farm_checker.sv
      - tb_div_farm.sv
